/* flist.f */
rtl/noc_addr_pkg.sv
rtl/router_pkg.sv
rtl/route_req_if.sv
rtl/xy_route.sv
rtl/fifo_arb.sv
rtl/router.sv
test/router_asserts.sv
test/router_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
TOP       ?= router_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
RUNFLAGS  ?= +verilator+error+limit+1000
FAIL_MSG  := CHECKS FAILED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	-./$(OBJ_DIR)/V$(TOP) $(RUNFLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "ALL CHECKS PASSED" $(LOG) || { echo "run ended early, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* test/router_tb.sv */
//========================================
// tile id fixed at row 2 col 1, all five inputs driven
// data word is {source, sequence} so an arrival maps back to its queue
//========================================
`timescale 1ns/100ps
`default_nettype none

module router_tb;

    import noc_addr_pkg::*;
    import router_pkg::*;

    localparam int TIMEOUT = 400;  // cycles allowed per wait loop

    logic                 clk;
    logic                 rst_n;
    t_tile_id             local_tile_id;
    logic [NUM_PORTS-1:0] in_valid;
    logic [NUM_PORTS-1:0] in_ready;
    logic [NUM_PORTS-1:0] out_valid;
    logic [NUM_PORTS-1:0] out_ready;
    t_tile_trans          in_trans  [NUM_PORTS];
    t_tile_trans          out_trans [NUM_PORTS];

    t_tile_trans exp_q  [NUM_PORTS][NUM_PORTS][$];  // [out][src], pushed at send
    int          rd_idx [NUM_PORTS][NUM_PORTS];     // next expected entry
    int          seq_no [NUM_PORTS];
    int          seed    = 80217;
    int          rr_last = -1;                      // previous east source
    logic        rr_check;                          // east alternation armed
    string       test_name;

    router dut0 (.*);  // tb names match the top ports

    bind router router_asserts u_asserts (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    // row first, then col, on the raw address bits
    function automatic t_port expected_port(input logic [31:0] raw);
        logic [1:0] row;
        logic [1:0] col;
        row = raw[31:30];
        col = raw[29:28];
        if (row != local_tile_id.row) return (row > local_tile_id.row) ? PORT_NORTH : PORT_SOUTH;
        if (col != local_tile_id.col) return (col > local_tile_id.col) ? PORT_EAST : PORT_WEST;
        return PORT_LOCAL;
    endfunction

    // call right after a rising edge; returns once the item is taken
    task automatic send(input int src, input logic [31:0] raw);
        t_tile_trans t;
        int          n;
        t.addr.raw     = raw;
        t.data         = {8'(src), 24'(seq_no[src])};
        t.opcode       = t_opcode'(2'($random(seed)));
        t.requestor_id = 4'($random(seed));
        seq_no[src]++;
        exp_q[expected_port(raw)][src].push_back(t);
        in_valid[src] <= 1'b1;
        in_trans[src] <= t;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT) abort_run($sformatf("input port %0d stalled, in_ready low", src));
        end while (!in_ready[src]);
    endtask

    // tile < 0 means fully random address
    task automatic burst(input int src, input int count, input int tile);
        logic [31:0] raw;
        for (int k = 0; k < count; k++) begin
            raw = $random(seed);
            if (tile >= 0) raw[31:28] = 4'(tile);
            send(src, raw);
        end
        in_valid[src] <= 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        int stuck;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            stuck = -1;
            for (int o = 0; o < NUM_PORTS; o++) begin
                for (int s = 0; s < NUM_PORTS; s++) begin
                    if (exp_q[o][s].size() > rd_idx[o][s]) stuck = o;
                end
            end
            if (n > TIMEOUT && stuck >= 0)
                abort_run($sformatf("%s: output port %0d stalled with items pending",
                                    test_name, stuck));
        end while (stuck >= 0);
    endtask

    //========================================
    // output monitor
    //========================================
    always @(posedge clk) begin
        int src;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (rst_n && out_valid[p] && out_ready[p]) begin
                src = int'(out_trans[p].data[31:24]);  // source tag
                assert (src < NUM_PORTS && exp_q[p][src].size() > rd_idx[p][src]) else
                    abort_run($sformatf("%s: port %0d sent an item not expected there",
                                        test_name, p));
                assert (out_trans[p] == exp_q[p][src][rd_idx[p][src]]) else
                    abort_run($sformatf("ERR %s: port %0d expected %h actual %h", test_name,
                                        p, exp_q[p][src][rd_idx[p][src]], out_trans[p]));
                rd_idx[p][src]++;
                if (rr_check && p == int'(PORT_EAST)) begin
                    assert (src != rr_last) else
                        abort_run($sformatf("ERR %s: east source expected %0d actual %0d",
                                  test_name, int'(PORT_SOUTH) + int'(PORT_LOCAL) - src, src));
                    rr_last = src;
                end
            end
        end
    end

    // bound checker failures end the run at the next edge
    always @(posedge clk) begin
        if (dut0.u_asserts.fail_count != 0) begin
            abort_run($sformatf("%s: router_asserts flagged %0d failed assertions",
                                test_name, dut0.u_asserts.fail_count));
        end
    end

    //========================================
    // test sequence
    //========================================
    initial begin
        rst_n         = 1'b0;
        local_tile_id = {2'd2, 2'd1};
        in_valid      = '0;
        out_ready     = '1;
        rr_check      = 1'b0;
        test_name     = "reset";
        for (int i = 0; i < NUM_PORTS; i++) begin
            in_trans[i] = '0;
        end
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        assert (out_valid == '0) else
            abort_run($sformatf("ERR reset: out_valid expected %b actual %b", 5'b0, out_valid));

        test_name = "local";  // address hits this tile
        burst(int'(PORT_WEST), 2, int'(local_tile_id));
        wait_drain();

        test_name = "xy_random";
        fork
            burst(int'(PORT_NORTH), 12, -1);
            burst(int'(PORT_EAST), 12, -1);
            burst(int'(PORT_SOUTH), 12, -1);
            burst(int'(PORT_WEST), 12, -1);
            burst(int'(PORT_LOCAL), 12, -1);
        join
        wait_drain();

        test_name = "backpressure";  // row 3 tiles all go north
        out_ready[PORT_NORTH] <= 1'b0;
        fork
            burst(int'(PORT_EAST), 4, 12);
            burst(int'(PORT_SOUTH), 4, 14);
            burst(int'(PORT_LOCAL), 4, 15);
            begin
                repeat (20) @(posedge clk);
                out_ready[PORT_NORTH] <= 1'b1;
            end
        join
        wait_drain();

        test_name = "round_robin";  // row 2, col 2 and 3 both go east
        rr_check  = 1'b1;
        fork
            burst(int'(PORT_SOUTH), 8, 11);
            burst(int'(PORT_LOCAL), 8, 10);
        join
        wait_drain();
        rr_check = 1'b0;

        if (dut0.u_asserts.fail_count == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            abort_run($sformatf("router_asserts flagged %0d failed assertions",
                                dut0.u_asserts.fail_count));
        end
    end

endmodule

`default_nettype wire

/* test/router_asserts.sv */
//========================================
// boundary checks on router, sampled at posedge clk
// in_ready rise check needs two reset edges in a row
//========================================
`timescale 1ns/100ps
`default_nettype none

module router_asserts (
    input logic                             clk,
    input logic                             rst_n,
    input logic [router_pkg::NUM_PORTS-1:0] in_ready,
    input logic [router_pkg::NUM_PORTS-1:0] out_valid,
    input router_pkg::t_tile_trans          out_trans [router_pkg::NUM_PORTS],
    input logic [router_pkg::NUM_PORTS-1:0] out_ready
);

    import router_pkg::*;

    int                   fail_count = 0;  // failed assertions so far
    logic                 rst_q;           // reset held at the last edge
    logic [NUM_PORTS-1:0] in_ready_q;

    always_ff @(posedge clk) begin
        rst_q      <= !rst_n;
        in_ready_q <= in_ready;
    end

    a_out_idle: assert property (@(posedge clk) !rst_n |-> out_valid == '0)
        else begin
            $error("out_valid high while in reset");
            fail_count++;
        end

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        // stalled output keeps its item
        a_hold: assert property (@(posedge clk) disable iff (!rst_n)
            out_valid[p] && !out_ready[p] |=> out_valid[p] && $stable(out_trans[p]))
            else begin
                $error("port %0d dropped or changed a stalled item", p);
                fail_count++;
            end

        a_no_rise: assert property (@(posedge clk)
            !rst_n && rst_q |-> !(in_ready[p] && !in_ready_q[p]))
            else begin
                $error("in_ready %0d rose during reset", p);
                fail_count++;
            end
    end

endmodule

`default_nettype wire

/* rtl/router.sv */
//========================================
// single tile router, 5 ports indexed by t_port
// min latency 2 edges; no VCs, no credits
//========================================
`timescale 1ns/100ps
`default_nettype none

module router (
    input  logic                             clk,
    input  logic                             rst_n,
    input  noc_addr_pkg::t_tile_id           local_tile_id,
    // inbound, one lane per port
    input  logic [router_pkg::NUM_PORTS-1:0] in_valid,
    input  router_pkg::t_tile_trans          in_trans [router_pkg::NUM_PORTS],
    output logic [router_pkg::NUM_PORTS-1:0] in_ready,
    // outbound
    output logic [router_pkg::NUM_PORTS-1:0] out_valid,
    output router_pkg::t_tile_trans          out_trans [router_pkg::NUM_PORTS],
    input  logic [router_pkg::NUM_PORTS-1:0] out_ready
);

    import router_pkg::*;

    route_req_if req_if [NUM_PORTS] ();  // one bundle per input

    // bundles flattened for the arbiters
    logic [NUM_PORTS-1:0] src_valid;
    t_port                src_dest  [NUM_PORTS];
    t_tile_trans          src_trans [NUM_PORTS];
    logic [NUM_PORTS-1:0] arb_ready [NUM_PORTS];  // [out][src]

    //========================================
    // route stages
    //========================================
    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_in
        xy_route u_route (
            .clk           (clk),
            .rst_n         (rst_n),
            .local_tile_id (local_tile_id),
            .in_valid      (in_valid[i]),
            .in_trans      (in_trans[i]),
            .in_ready      (in_ready[i]),
            .req           (req_if[i])
        );

        assign src_valid[i] = req_if[i].valid;
        assign src_dest[i]  = req_if[i].dest;
        assign src_trans[i] = req_if[i].trans;

        // transpose: source i sees bit i of every arbiter
        for (genvar j = 0; j < NUM_PORTS; j++) begin : g_rdy
            assign req_if[i].ready_by_out[j] = arb_ready[j][i];
        end
    end

    //========================================
    // output arbiters
    //========================================
    for (genvar j = 0; j < NUM_PORTS; j++) begin : g_out
        fifo_arb #(
            .out_port (t_port'(j))
        ) u_arb (
            .clk       (clk),
            .rst_n     (rst_n),
            .src_valid (src_valid),
            .src_dest  (src_dest),
            .src_trans (src_trans),
            .src_ready (arb_ready[j]),
            .out_valid (out_valid[j]),
            .out_trans (out_trans[j]),
            .out_ready (out_ready[j])
        );
    end

endmodule

`default_nettype wire

/* rtl/fifo_arb.sv */
//========================================
// one per output port; FIFO_DEPTH-entry FIFO per source
// round-robin from last winner, one output register
//========================================
`timescale 1ns/100ps
`default_nettype none

module fifo_arb #(
    parameter router_pkg::t_port out_port = router_pkg::PORT_NORTH
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [router_pkg::NUM_PORTS-1:0]  src_valid,
    input  router_pkg::t_port                 src_dest  [router_pkg::NUM_PORTS],
    input  router_pkg::t_tile_trans           src_trans [router_pkg::NUM_PORTS],
    output logic [router_pkg::NUM_PORTS-1:0]  src_ready,
    output logic                              out_valid,
    output router_pkg::t_tile_trans           out_trans,
    input  logic                              out_ready
);

    import router_pkg::*;

    t_tile_trans           mem    [NUM_PORTS][FIFO_DEPTH];  // per-source storage
    logic [FIFO_PTR_W-1:0] wr_ptr [NUM_PORTS];
    logic [FIFO_PTR_W-1:0] rd_ptr [NUM_PORTS];
    logic [FIFO_CNT_W-1:0] count  [NUM_PORTS];
    logic [NUM_PORTS-1:0]  not_empty;
    logic [NUM_PORTS-1:0]  push;
    logic [NUM_PORTS-1:0]  pop;
    t_port                 last_win;   // rr pointer
    t_port                 win;
    logic                  win_found;
    logic                  load;       // output reg free this cycle

    // wrap at FIFO_DEPTH, also for non power-of-2 depths
    function automatic logic [FIFO_PTR_W-1:0] ptr_inc(input logic [FIFO_PTR_W-1:0] p);
        if (p == FIFO_PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return p + FIFO_PTR_W'(1);
    endfunction

    //========================================
    // source side
    //========================================
    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            not_empty[i] = (count[i] != '0);
            src_ready[i] = (count[i] != FIFO_CNT_W'(FIFO_DEPTH));  // full only
            push[i]      = src_valid[i] && (src_dest[i] == out_port) && src_ready[i];
        end
    end

    //========================================
    // round-robin pick
    //========================================
    always_comb begin
        int cand;
        win       = last_win;
        win_found = 1'b0;
        // start one past last winner, last winner itself checked last
        for (int k = 1; k <= NUM_PORTS; k++) begin
            cand = (int'(last_win) + k) % NUM_PORTS;
            if (!win_found && not_empty[cand]) begin
                win       = t_port'(cand);
                win_found = 1'b1;
            end
        end
    end

    assign load = !out_valid || out_ready;

    always_comb begin
        pop = '0;
        if (load && win_found) begin
            pop[win] = 1'b1;  // head moves into output reg
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                wr_ptr[i] <= '0;
                rd_ptr[i] <= '0;
                count[i]  <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (push[i]) wr_ptr[i] <= ptr_inc(wr_ptr[i]);
                if (pop[i])  rd_ptr[i] <= ptr_inc(rd_ptr[i]);
                count[i] <= count[i] + FIFO_CNT_W'(push[i]) - FIFO_CNT_W'(pop[i]);
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (push[i]) mem[i][wr_ptr[i]] <= src_trans[i];
        end
    end

    //========================================
    // output register
    //========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            last_win  <= PORT_LOCAL;  // north gets first turn
        end else if (load) begin
            out_valid <= win_found;
            if (win_found) last_win <= win;
        end
    end

    always_ff @(posedge clk) begin
        if (load && win_found) begin
            out_trans <= mem[win][rd_ptr[win]];
        end
    end

endmodule

`default_nettype wire

/* rtl/xy_route.sv */
//========================================
// single-entry stage, row-first dimension-ordered routing
// item leaves only when the arbiter at dest has room
//========================================
`timescale 1ns/100ps
`default_nettype none

module xy_route (
    input  logic                    clk,
    input  logic                    rst_n,
    input  noc_addr_pkg::t_tile_id  local_tile_id,
    input  logic                    in_valid,
    input  router_pkg::t_tile_trans in_trans,
    output logic                    in_ready,
    route_req_if.route              req
);

    import noc_addr_pkg::*;
    import router_pkg::*;

    t_addr in_addr;    // field view of incoming address
    t_port next_dest;  // decoded before the register
    logic  drain;      // held item moves on this cycle

    assign in_addr = in_trans.addr;

    // row first, then col, else it's ours
    always_comb begin
        if (in_addr.fields.row > local_tile_id.row) begin
            next_dest = PORT_NORTH;
        end else if (in_addr.fields.row < local_tile_id.row) begin
            next_dest = PORT_SOUTH;
        end else if (in_addr.fields.col > local_tile_id.col) begin
            next_dest = PORT_EAST;
        end else if (in_addr.fields.col < local_tile_id.col) begin
            next_dest = PORT_WEST;
        end else begin
            next_dest = PORT_LOCAL;
        end
    end

    assign drain    = req.valid && req.ready_by_out[req.dest];
    assign in_ready = !req.valid || drain;  // state only, never in_valid

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req.valid <= 1'b0;
        end else if (in_ready) begin
            req.valid <= in_valid;  // refill or go empty
        end
    end

    // payload + dest latched together
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            req.trans <= in_trans;
            req.dest  <= next_dest;
        end
    end

endmodule

`default_nettype wire

/* rtl/route_req_if.sv */
//========================================
// one bundle per input port
// ready_by_out bit j comes from the arbiter of output j
//========================================
`timescale 1ns/100ps
`default_nettype none

interface route_req_if;

    import router_pkg::*;

    logic                 valid;         // route register holds an item
    t_tile_trans          trans;         // the registered item
    t_port                dest;          // output picked by xy decode
    logic [NUM_PORTS-1:0] ready_by_out;  // per-output FIFO has room for us

    // route stage side
    modport route (
        output valid, trans, dest,
        input  ready_by_out
    );

    // arbiter side
    modport arb (
        input  valid, trans, dest,
        output ready_by_out
    );

endinterface

`default_nettype wire

/* rtl/router_pkg.sv */
//========================================
// port numbering doubles as the source index inside fifo_arb
// opcode is carried through, never decoded by the router
//========================================
`default_nettype none

package router_pkg;

    import noc_addr_pkg::*;

    localparam int NUM_PORTS = 5;

    // 5 ports, index into every per-port array
    typedef enum logic [2:0] {
        PORT_NORTH = 3'd0,
        PORT_EAST  = 3'd1,
        PORT_SOUTH = 3'd2,
        PORT_WEST  = 3'd3,
        PORT_LOCAL = 3'd4
    } t_port;

    typedef enum logic [1:0] {
        OP_RD     = 2'd0,
        OP_WR     = 2'd1,
        OP_RD_RSP = 2'd2,
        OP_WR_RSP = 2'd3
    } t_opcode;

    localparam int DATA_W = 32;

    // 70 bits on the wire
    typedef struct packed {
        t_addr             addr;          // 32
        logic [DATA_W-1:0] data;          // 32
        t_opcode           opcode;        // 2
        t_tile_id          requestor_id;  // 4
    } t_tile_trans;

    //========================================
    // per-source FIFO sizing
    //========================================
    localparam int FIFO_DEPTH = 2;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);      // read/write pointer
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);  // occupancy 0..FIFO_DEPTH

endpackage

`default_nettype wire

/* rtl/noc_addr_pkg.sv */
//========================================
// 4x4 mesh only; tile id sits in the top 4 address bits
// row above col, then a 28-bit in-tile offset
//========================================
`default_nettype none

package noc_addr_pkg;

    localparam int ROW_W    = 2;   // 4 rows
    localparam int COL_W    = 2;   // 4 cols
    localparam int OFFSET_W = 28;  // in-tile byte offset

    typedef struct packed {
        logic [ROW_W-1:0] row;
        logic [COL_W-1:0] col;
    } t_tile_id;

    // routing view of an address
    typedef struct packed {
        logic [ROW_W-1:0]    row;     // bits 31:30
        logic [COL_W-1:0]    col;     // bits 29:28
        logic [OFFSET_W-1:0] offset;
    } t_addr_fields;

    // raw word for agents, field view for the router
    typedef union packed {
        logic [ROW_W+COL_W+OFFSET_W-1:0] raw;
        t_addr_fields                    fields;
    } t_addr;

endpackage

`default_nettype wire
